// File: Bender.yml
package:
  name: cpu6502_lite

sources:
  - design/cpu_bus_pkg.sv
  - design/cpu_ctrl_pkg.sv
  - design/program_counter.sv
  - design/register_file.sv
  - design/alu.sv
  - design/bus_router.sv
  - design/timing_decoder.sv
  - design/cpu6502_lite.sv
  - target: test
    files:
      - tb/tb_cpu6502_lite.sv

// File: cpu6502_lite.f
design/cpu_bus_pkg.sv
design/cpu_ctrl_pkg.sv
design/program_counter.sv
design/register_file.sv
design/alu.sv
design/bus_router.sv
design/timing_decoder.sv
design/cpu6502_lite.sv
tb/tb_cpu6502_lite.sv

// File: design/alu.sv
`timescale 1ns/1ps

module alu
    import cpu_bus_pkg::*;
    import cpu_ctrl_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_reset,
    input  alu_op_e           i_op,
    input  logic              i_load,
    input  logic [DATA_W-1:0] i_a,
    input  logic [DATA_W-1:0] i_b,
    input  logic              i_carry_set,
    input  logic              i_carry_clr,
    output logic [DATA_W-1:0] o_result
);

    // Status bit positions, N Z C
    localparam int ST_C = 0;
    localparam int ST_Z = 1;
    localparam int ST_N = 2;

    logic [2:0]        r_status;
    logic [DATA_W-1:0] r_result;
    logic [DATA_W:0]   sum;
    logic [DATA_W-1:0] result;

    assign sum = {1'b0, i_a} + {1'b0, i_b} + {{DATA_W{1'b0}}, r_status[ST_C]};

    always_comb begin
        case (i_op)
            ALU_ADC: result = sum[DATA_W-1:0];
            ALU_AND: result = i_a & i_b;
            ALU_ORA: result = i_a | i_b;
            ALU_EOR: result = i_a ^ i_b;
            ALU_INC: result = i_b + 1'b1;
            ALU_DEC: result = i_b - 1'b1;
            default: result = i_b;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_load) r_result <= result;
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            r_status <= '0;
        end else begin
            if (i_carry_clr) r_status[ST_C] <= 1'b0;
            else if (i_carry_set) r_status[ST_C] <= 1'b1;
            else if (i_load && i_op == ALU_ADC) r_status[ST_C] <= sum[DATA_W];
            if (i_load) begin
                r_status[ST_Z] <= (result == '0);
                r_status[ST_N] <= result[DATA_W-1];
            end
        end
    end

    assign o_result = r_result;

endmodule

// File: design/bus_router.sv
`timescale 1ns/1ps

module bus_router
    import cpu_bus_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_reset,
    input  logic [DATA_W-1:0] i_data,
    input  logic              i_dl_load_lo,
    input  logic              i_dl_load_hi,
    input  sb_src_e           i_sb_src,
    input  addr_src_e         i_addr_src,
    input  logic              i_rw,
    input  logic [ADDR_W-1:0] i_pc,
    input  logic [DATA_W-1:0] i_x,
    input  logic [DATA_W-1:0] i_y,
    input  logic [DATA_W-1:0] i_ac,
    input  logic [DATA_W-1:0] i_alu,
    output logic [DATA_W-1:0] o_bus,
    output logic [ADDR_W-1:0] o_target,
    output logic [ADDR_W-1:0] o_address,
    output logic [DATA_W-1:0] o_data
);

    // Operand address bytes
    logic [DATA_W-1:0] r_adl;
    logic [DATA_W-1:0] r_adh;
    logic [ADDR_W-1:0] r_address;
    logic [DATA_W-1:0] r_dor;

    always_ff @(posedge i_clk) begin
        if (i_dl_load_lo) r_adl <= i_data;
        if (i_dl_load_hi) r_adh <= i_data;
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            r_address <= '0;
            r_dor     <= '0;
        end else begin
            r_address <= o_address;
            r_dor     <= o_data;
        end
    end

    // Memory reads combinationally, so the input byte is used as it arrives
    always_comb begin
        case (i_sb_src)
            SB_X:    o_bus = i_x;
            SB_Y:    o_bus = i_y;
            SB_AC:   o_bus = i_ac;
            SB_ALU:  o_bus = i_alu;
            default: o_bus = i_data;
        endcase
    end

    always_comb begin
        case (i_addr_src)
            ADDR_OPERAND: o_address = {r_adh, r_adl};
            ADDR_HELD:    o_address = r_address;
            default:      o_address = i_pc;
        endcase
    end

    // JMP takes the high byte straight off the data bus
    assign o_target = {i_data, r_adl};
    assign o_data   = i_rw ? r_dor : o_bus;

endmodule

// File: design/cpu6502_lite.sv
`timescale 1ns/1ps

module cpu6502_lite
    import cpu_bus_pkg::*;
    import cpu_ctrl_pkg::*;
#(
    parameter logic [ADDR_W-1:0] RESET_VECTOR = 16'h0200
) (
    input  logic              i_clk,
    input  logic              i_reset,
    input  logic [DATA_W-1:0] i_data,
    output logic [ADDR_W-1:0] o_address,
    output logic [DATA_W-1:0] o_data,
    // 1 = read, 0 = write
    output logic              o_rw,
    output logic              o_sync
);

    // Control from the decoder
    logic      w_pc_inc;
    logic      w_pc_load;
    logic      w_dl_load_lo;
    logic      w_dl_load_hi;
    addr_src_e w_addr_src;
    sb_src_e   w_sb_src;
    reg_load_e w_reg_load;
    alu_op_e   w_alu_op;
    logic      w_alu_load;
    logic      w_carry_set;
    logic      w_carry_clr;

    // Datapath
    logic [ADDR_W-1:0] w_pc;
    logic [ADDR_W-1:0] w_target;
    logic [DATA_W-1:0] w_bus;
    logic [DATA_W-1:0] w_x;
    logic [DATA_W-1:0] w_y;
    logic [DATA_W-1:0] w_ac;
    logic [DATA_W-1:0] w_alu;

    timing_decoder decoder (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_data       (i_data),
        .o_sync       (o_sync),
        .o_rw         (o_rw),
        .o_pc_inc     (w_pc_inc),
        .o_pc_load    (w_pc_load),
        .o_dl_load_lo (w_dl_load_lo),
        .o_dl_load_hi (w_dl_load_hi),
        .o_addr_src   (w_addr_src),
        .o_sb_src     (w_sb_src),
        .o_reg_load   (w_reg_load),
        .o_alu_op     (w_alu_op),
        .o_alu_load   (w_alu_load),
        .o_carry_set  (w_carry_set),
        .o_carry_clr  (w_carry_clr)
    );

    program_counter #(
        .RESET_VECTOR (RESET_VECTOR)
    ) pc (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_inc    (w_pc_inc),
        .i_load   (w_pc_load),
        .i_target (w_target),
        .o_pc     (w_pc)
    );

    register_file regs (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_load  (w_reg_load),
        .i_bus   (w_bus),
        .o_x     (w_x),
        .o_y     (w_y),
        .o_ac    (w_ac)
    );

    alu alu (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_op        (w_alu_op),
        .i_load      (w_alu_load),
        .i_a         (w_ac),
        .i_b         (w_bus),
        .i_carry_set (w_carry_set),
        .i_carry_clr (w_carry_clr),
        .o_result    (w_alu)
    );

    bus_router routing (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_data       (i_data),
        .i_dl_load_lo (w_dl_load_lo),
        .i_dl_load_hi (w_dl_load_hi),
        .i_sb_src     (w_sb_src),
        .i_addr_src   (w_addr_src),
        .i_rw         (o_rw),
        .i_pc         (w_pc),
        .i_x          (w_x),
        .i_y          (w_y),
        .i_ac         (w_ac),
        .i_alu        (w_alu),
        .o_bus        (w_bus),
        .o_target     (w_target),
        .o_address    (o_address),
        .o_data       (o_data)
    );

endmodule

// File: design/cpu_bus_pkg.sv
package cpu_bus_pkg;

    // Processor bus widths
    localparam int DATA_W = 8;
    localparam int ADDR_W = 16;

    // Source that drives the internal bus for one cycle
    typedef enum logic [2:0] {
        SB_DL,
        SB_X,
        SB_Y,
        SB_AC,
        SB_ALU
    } sb_src_e;

    // Register written from the internal bus at the end of the cycle
    typedef enum logic [1:0] {
        LOAD_NONE,
        LOAD_X,
        LOAD_Y,
        LOAD_AC
    } reg_load_e;

    // Value placed on the address bus
    typedef enum logic [1:0] {
        ADDR_PC,
        ADDR_OPERAND,
        ADDR_HELD
    } addr_src_e;

endpackage

// File: design/cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

    // T0 is the opcode fetch
    typedef enum logic [1:0] {
        T0,
        T1,
        T2,
        T3
    } tstate_e;

    typedef enum logic [2:0] {
        ALU_ADC,
        ALU_AND,
        ALU_ORA,
        ALU_EOR,
        ALU_INC,
        ALU_DEC,
        ALU_PASS
    } alu_op_e;

    // Opcode byte, either whole or split as aaa_bbb_cc
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [2:0] group;
            logic [2:0] mode;
            logic [1:0] cls;
        } fld;
    } opcode_u;

    // Field codes of the cc = 01 group
    localparam logic [1:0] CLS_ALU  = 2'b01;
    localparam logic [2:0] MODE_IMM = 3'b010;
    localparam logic [2:0] MODE_ABS = 3'b011;
    localparam logic [2:0] GRP_ORA  = 3'd0;
    localparam logic [2:0] GRP_AND  = 3'd1;
    localparam logic [2:0] GRP_EOR  = 3'd2;
    localparam logic [2:0] GRP_ADC  = 3'd3;
    localparam logic [2:0] GRP_STA  = 3'd4;
    localparam logic [2:0] GRP_LDA  = 3'd5;

    // Opcodes outside the field-decoded group
    localparam logic [7:0] OP_LDX_IMM = 8'hA2;
    localparam logic [7:0] OP_LDX_ABS = 8'hAE;
    localparam logic [7:0] OP_LDY_IMM = 8'hA0;
    localparam logic [7:0] OP_LDY_ABS = 8'hAC;
    localparam logic [7:0] OP_STX_ABS = 8'h8E;
    localparam logic [7:0] OP_STY_ABS = 8'h8C;
    localparam logic [7:0] OP_TAX     = 8'hAA;
    localparam logic [7:0] OP_TAY     = 8'hA8;
    localparam logic [7:0] OP_TXA     = 8'h8A;
    localparam logic [7:0] OP_TYA     = 8'h98;
    localparam logic [7:0] OP_INX     = 8'hE8;
    localparam logic [7:0] OP_INY     = 8'hC8;
    localparam logic [7:0] OP_DEX     = 8'hCA;
    localparam logic [7:0] OP_DEY     = 8'h88;
    localparam logic [7:0] OP_CLC     = 8'h18;
    localparam logic [7:0] OP_SEC     = 8'h38;
    localparam logic [7:0] OP_NOP     = 8'hEA;
    localparam logic [7:0] OP_JMP_ABS = 8'h4C;

endpackage

// File: design/program_counter.sv
`timescale 1ns/1ps

module program_counter
    import cpu_bus_pkg::*;
#(
    parameter logic [ADDR_W-1:0] RESET_VECTOR = 16'h0200
) (
    input  logic              i_clk,
    input  logic              i_reset,
    input  logic              i_inc,
    input  logic              i_load,
    input  logic [ADDR_W-1:0] i_target,
    output logic [ADDR_W-1:0] o_pc
);

    logic [DATA_W-1:0] r_pcl;
    logic [DATA_W-1:0] r_pch;
    // Low byte plus one, with the carry into PCH on top
    logic [DATA_W:0]   pcl_inc;

    assign pcl_inc = {1'b0, r_pcl} + 1'b1;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            {r_pch, r_pcl} <= RESET_VECTOR;
        end else if (i_load) begin
            {r_pch, r_pcl} <= i_target;
        end else if (i_inc) begin
            r_pcl <= pcl_inc[DATA_W-1:0];
            r_pch <= r_pch + DATA_W'(pcl_inc[DATA_W]);
        end
    end

    assign o_pc = {r_pch, r_pcl};

endmodule

// File: design/register_file.sv
`timescale 1ns/1ps

module register_file
    import cpu_bus_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_reset,
    input  reg_load_e         i_load,
    input  logic [DATA_W-1:0] i_bus,
    output logic [DATA_W-1:0] o_x,
    output logic [DATA_W-1:0] o_y,
    output logic [DATA_W-1:0] o_ac
);

    // Index registers
    logic [DATA_W-1:0] r_x;
    logic [DATA_W-1:0] r_y;

    // Accumulator
    logic [DATA_W-1:0] r_ac;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            r_x  <= '0;
            r_y  <= '0;
            r_ac <= '0;
        end else begin
            case (i_load)
                LOAD_X: begin
                    r_x <= i_bus;
                end
                LOAD_Y: begin
                    r_y <= i_bus;
                end
                LOAD_AC: begin
                    r_ac <= i_bus;
                end
                LOAD_NONE: ;
                default: ;
            endcase
        end
    end

    assign o_x  = r_x;
    assign o_y  = r_y;
    // Also operand A of the ALU
    assign o_ac = r_ac;

endmodule

// File: design/timing_decoder.sv
`timescale 1ns/1ps

module timing_decoder
    import cpu_bus_pkg::*;
    import cpu_ctrl_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_reset,
    input  logic [DATA_W-1:0] i_data,
    output logic              o_sync,
    output logic              o_rw,
    output logic              o_pc_inc,
    output logic              o_pc_load,
    output logic              o_dl_load_lo,
    output logic              o_dl_load_hi,
    output addr_src_e         o_addr_src,
    output sb_src_e           o_sb_src,
    output reg_load_e         o_reg_load,
    output alu_op_e           o_alu_op,
    output logic              o_alu_load,
    output logic              o_carry_set,
    output logic              o_carry_clr
);

    opcode_u   r_ir;
    tstate_e   r_state;
    tstate_e   last_state;
    // ALU result still to be written back in the next T0
    reg_load_e r_wb;

    logic      mode_imm;
    logic      mode_abs;
    logic      op_imm;
    logic      op_abs;
    logic      op_jmp;
    logic      op_store;
    logic      op_alu;
    logic      op_clc;
    logic      op_sec;
    reg_load_e op_dest;
    sb_src_e   op_src;
    alu_op_e   op_alu_op;
    logic      write_cycle;

    assign mode_imm = (r_ir.fld.mode == MODE_IMM);
    assign mode_abs = (r_ir.fld.mode == MODE_ABS);

    always_comb begin
        op_imm    = 1'b0;
        op_abs    = 1'b0;
        op_jmp    = 1'b0;
        op_store  = 1'b0;
        op_alu    = 1'b0;
        op_clc    = 1'b0;
        op_sec    = 1'b0;
        op_dest   = LOAD_NONE;
        op_src    = SB_DL;
        op_alu_op = ALU_PASS;
        if (r_ir.fld.cls == CLS_ALU) begin
            // Only immediate ALU ops and absolute LDA/STA are supported here
            case (r_ir.fld.group)
                GRP_ORA: begin
                    op_alu    = mode_imm;
                    op_alu_op = ALU_ORA;
                end
                GRP_AND: begin
                    op_alu    = mode_imm;
                    op_alu_op = ALU_AND;
                end
                GRP_EOR: begin
                    op_alu    = mode_imm;
                    op_alu_op = ALU_EOR;
                end
                GRP_ADC: begin
                    op_alu    = mode_imm;
                    op_alu_op = ALU_ADC;
                end
                GRP_LDA: begin
                    op_imm  = mode_imm;
                    op_abs  = mode_abs;
                    op_dest = LOAD_AC;
                end
                GRP_STA: begin
                    op_abs   = mode_abs;
                    op_store = mode_abs;
                    op_src   = SB_AC;
                end
                default: ;
            endcase
            if (op_alu) begin
                op_imm  = 1'b1;
                op_dest = LOAD_AC;
            end
        end else begin
            case (r_ir.raw)
                OP_LDX_IMM: begin
                    op_imm  = 1'b1;
                    op_dest = LOAD_X;
                end
                OP_LDX_ABS: begin
                    op_abs  = 1'b1;
                    op_dest = LOAD_X;
                end
                OP_LDY_IMM: begin
                    op_imm  = 1'b1;
                    op_dest = LOAD_Y;
                end
                OP_LDY_ABS: begin
                    op_abs  = 1'b1;
                    op_dest = LOAD_Y;
                end
                OP_STX_ABS: begin
                    op_abs   = 1'b1;
                    op_store = 1'b1;
                    op_src   = SB_X;
                end
                OP_STY_ABS: begin
                    op_abs   = 1'b1;
                    op_store = 1'b1;
                    op_src   = SB_Y;
                end
                OP_TAX: begin
                    op_src  = SB_AC;
                    op_dest = LOAD_X;
                end
                OP_TAY: begin
                    op_src  = SB_AC;
                    op_dest = LOAD_Y;
                end
                OP_TXA: begin
                    op_src  = SB_X;
                    op_dest = LOAD_AC;
                end
                OP_TYA: begin
                    op_src  = SB_Y;
                    op_dest = LOAD_AC;
                end
                OP_INX: begin
                    op_alu    = 1'b1;
                    op_alu_op = ALU_INC;
                    op_src    = SB_X;
                    op_dest   = LOAD_X;
                end
                OP_INY: begin
                    op_alu    = 1'b1;
                    op_alu_op = ALU_INC;
                    op_src    = SB_Y;
                    op_dest   = LOAD_Y;
                end
                OP_DEX: begin
                    op_alu    = 1'b1;
                    op_alu_op = ALU_DEC;
                    op_src    = SB_X;
                    op_dest   = LOAD_X;
                end
                OP_DEY: begin
                    op_alu    = 1'b1;
                    op_alu_op = ALU_DEC;
                    op_src    = SB_Y;
                    op_dest   = LOAD_Y;
                end
                OP_CLC:     op_clc = 1'b1;
                OP_SEC:     op_sec = 1'b1;
                OP_JMP_ABS: op_jmp = 1'b1;
                // Unknown opcodes run as NOP
                default: ;
            endcase
        end
    end

    always_comb begin
        if (op_abs) last_state = T3;
        else if (op_jmp) last_state = T2;
        else last_state = T1;
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            r_state  <= T0;
            r_ir.raw <= OP_NOP;
            r_wb     <= LOAD_NONE;
        end else begin
            if (r_state != last_state) begin
                r_state <= tstate_e'(r_state + 2'd1);
            end else begin
                r_state <= T0;
            end
            if (r_state == T0) r_ir.raw <= i_data;
            // Write-back is consumed in T0 and armed again by an ALU op in T1
            if (r_state == T1 && op_alu) r_wb <= op_dest;
            else if (r_state == T0) r_wb <= LOAD_NONE;
        end
    end

    always_comb begin
        write_cycle  = 1'b0;
        o_pc_inc     = 1'b0;
        o_pc_load    = 1'b0;
        o_dl_load_lo = 1'b0;
        o_dl_load_hi = 1'b0;
        o_addr_src   = ADDR_PC;
        o_sb_src     = op_src;
        o_reg_load   = LOAD_NONE;
        o_alu_op     = op_alu_op;
        o_alu_load   = 1'b0;
        o_carry_set  = 1'b0;
        o_carry_clr  = 1'b0;
        case (r_state)
            T0: begin
                o_pc_inc   = 1'b1;
                o_sb_src   = SB_ALU;
                o_reg_load = r_wb;
            end
            T1: begin
                if (op_abs || op_jmp) begin
                    o_pc_inc     = 1'b1;
                    o_dl_load_lo = 1'b1;
                end else begin
                    // Implied ops keep the fetch address on the bus
                    o_pc_inc    = op_imm;
                    o_addr_src  = op_imm ? ADDR_PC : ADDR_HELD;
                    o_alu_load  = op_alu;
                    o_reg_load  = op_alu ? LOAD_NONE : op_dest;
                    o_carry_set = op_sec;
                    o_carry_clr = op_clc;
                end
            end
            T2: begin
                if (op_jmp) begin
                    o_pc_load = 1'b1;
                end else begin
                    o_pc_inc     = 1'b1;
                    o_dl_load_hi = 1'b1;
                end
            end
            T3: begin
                o_addr_src  = ADDR_OPERAND;
                write_cycle = op_store;
                o_reg_load  = op_dest;
            end
            default: ;
        endcase
    end

    // Reset must block a store that is already on the bus
    assign o_rw   = !(write_cycle && !i_reset);
    assign o_sync = (r_state == T0) && !i_reset;

endmodule

// File: tb/cpu6502_lite_patterns.txt
// 1 addr count bytes... = memory bytes, 2 addr cycles = opcode fetch and cycles to the next one
// 3 addr data = expected write, 4 addr = store fetch with reset in its data cycle, 0 = end
// Program at the reset vector
1 0200 0F 8D 00 03 8E 01 03 8C 02 03 A9 5A A2 A7 A0 01
1 020F 0F 8D 03 03 8E 04 03 8C 05 03 AD 00 04 AE 01 04
1 021E 0C AC 02 04 8D 06 03 8E 07 03 8C 08 03
1 022A 0C 18 69 14 8D 09 03 38 69 0F 8D 0A 03
1 0236 0C 69 C8 69 05 8D 0B 03 29 F3 8D 0C 03
1 0242 0A 09 C1 8D 0D 03 49 FF 8D 0E 03
1 024C 0A AA 8E 0F 03 A0 00 88 8C 10 03
1 0256 0A 98 8D 11 03 A2 FF E8 8E 12 03
1 0260 09 C8 8C 13 03 CA 8A 8D 14 03
1 0269 0A A9 37 A8 8C 15 03 EA 4C 80 02
1 0280 08 A2 42 8E 16 03 8D 17 03
// Load data, never stored to
1 0400 03 3C C5 81
// Fetch sequence
2 0200 4  2 0203 4  2 0206 4  2 0209 2  2 020B 2  2 020D 2
2 020F 4  2 0212 4  2 0215 4  2 0218 4  2 021B 4  2 021E 4
2 0221 4  2 0224 4  2 0227 4  2 022A 2  2 022B 2  2 022D 4
2 0230 2  2 0231 2  2 0233 4  2 0236 2  2 0238 2  2 023A 4
2 023D 2  2 023F 4  2 0242 2  2 0244 4  2 0247 2  2 0249 4
2 024C 2  2 024D 4  2 0250 2  2 0252 2  2 0253 4  2 0256 2
2 0257 4  2 025A 2  2 025C 2  2 025D 4  2 0260 2  2 0261 4
2 0264 2  2 0265 2  2 0266 4  2 0269 2  2 026B 2  2 026C 4
2 026F 2  2 0270 3  2 0280 2  2 0282 4
4 0285
// Restart after the second reset
2 0200 4  2 0203 4  2 0206 4  2 0209 0
// Expected writes
3 0300 00  3 0301 00  3 0302 00  3 0303 5A
3 0304 A7  3 0305 01  3 0306 3C  3 0307 C5
3 0308 81  3 0309 50  3 030A 60  3 030B 2E
3 030C 22  3 030D E3  3 030E 1C  3 030F 1C
3 0310 FF  3 0311 FF  3 0312 00  3 0313 00
3 0314 FF  3 0315 37  3 0316 42
// Registers read back as zero after the restart
3 0300 00  3 0301 00  3 0302 00
0

// File: tb/tb_cpu6502_lite.sv
`timescale 1ns/1ps

module tb_cpu6502_lite;

    localparam logic [15:0] RESET_VECTOR  = 16'h0200;
    localparam int          FETCH_TIMEOUT = 64;
    localparam int          PATTERN_WORDS = 1024;

    // Record types in the pattern file
    localparam logic [15:0] REC_END   = 16'd0;
    localparam logic [15:0] REC_MEM   = 16'd1;
    localparam logic [15:0] REC_FETCH = 16'd2;
    localparam logic [15:0] REC_WRITE = 16'd3;
    localparam logic [15:0] REC_RESET = 16'd4;

    logic        clk;
    logic        reset;
    logic [7:0]  rd_data;
    logic [15:0] address;
    logic [7:0]  wr_data;
    logic        rw;
    logic        sync;

    logic [7:0]  mem [0:65535];
    logic [15:0] words [0:PATTERN_WORDS-1];

    // Expected opcode fetches and writes, in program order
    logic [15:0] fetch_kind [$];
    logic [15:0] fetch_addr [$];
    logic [15:0] fetch_gap [$];
    logic [15:0] exp_wr_addr [$];
    logic [15:0] exp_wr_data [$];

    int checks;
    int error_count;
    int write_count;

    cpu6502_lite #(
        .RESET_VECTOR (RESET_VECTOR)
    ) i_cpu6502_lite (
        .i_clk     (clk),
        .i_reset   (reset),
        .i_data    (rd_data),
        .o_address (address),
        .o_data    (wr_data),
        .o_rw      (rw),
        .o_sync    (sync)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // Memory answers reads in the same cycle
    assign rd_data = mem[address];

    always @(posedge clk) begin
        if (rw === 1'b0) mem[address] <= wr_data;
    end

    task automatic compare_value(input string name, input logic [15:0] expected,
                                 input logic [15:0] actual);
        checks++;
        assert (actual === expected) else begin
            error_count++;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic require_true(input logic cond, input string what);
        checks++;
        assert (cond === 1'b1) else begin
            error_count++;
            $display("%s", what);
        end
    endtask

    task automatic load_patterns();
        int          p;
        int          i;
        int          n;
        logic [15:0] kind;
        logic [15:0] addr;
        logic [15:0] a;
        for (i = 0; i < 65536; i++) begin
            a = i[15:0];
            mem[i] = a[15:8] ^ a[7:0] ^ 8'h6B;
        end
        for (i = 0; i < PATTERN_WORDS; i++) words[i] = REC_END;
        $readmemh("tb/cpu6502_lite_patterns.txt", words);
        p = 0;
        while (p < PATTERN_WORDS - 3 && words[p] != REC_END) begin
            kind = words[p];
            addr = words[p + 1];
            case (kind)
                REC_MEM: begin
                    n = words[p + 2];
                    for (i = 0; i < n; i++) mem[addr + i[15:0]] = words[p + 3 + i][7:0];
                    p = p + 3 + n;
                end
                REC_FETCH: begin
                    fetch_kind.push_back(REC_FETCH);
                    fetch_addr.push_back(addr);
                    fetch_gap.push_back(words[p + 2]);
                    p = p + 3;
                end
                REC_WRITE: begin
                    exp_wr_addr.push_back(addr);
                    exp_wr_data.push_back(words[p + 2]);
                    p = p + 3;
                end
                REC_RESET: begin
                    fetch_kind.push_back(REC_RESET);
                    fetch_addr.push_back(addr);
                    fetch_gap.push_back(16'd0);
                    p = p + 2;
                end
                default: begin
                    require_true(1'b0, $sformatf("unknown record type %h in pattern file", kind));
                    p = PATTERN_WORDS;
                end
            endcase
        end
    endtask

    // Bus must stay idle while reset is high
    task automatic hold_reset(input int cycles);
        int i;
        for (i = 0; i < cycles; i++) begin
            @(negedge clk);
            require_true(rw === 1'b1, "o_rw went low while reset was asserted");
            require_true(sync === 1'b0, "o_sync went high while reset was asserted");
        end
        @(posedge clk);
        #1 reset = 1'b0;
    endtask

    task automatic wait_for_fetch(output int gap, output logic timed_out);
        gap = 0;
        do begin
            @(negedge clk);
            gap++;
        end while (sync !== 1'b1 && gap < FETCH_TIMEOUT);
        timed_out = (sync !== 1'b1);
    endtask

    always @(negedge clk) begin : write_monitor
        logic [15:0] exp_addr;
        logic [15:0] exp_data;
        if (rw === 1'b0) begin
            require_true(exp_wr_addr.size() != 0,
                         $sformatf("unexpected write of %h to %h", wr_data, address));
            if (exp_wr_addr.size() != 0) begin
                exp_addr = exp_wr_addr.pop_front();
                exp_data = exp_wr_data.pop_front();
                compare_value($sformatf("write %0d address", write_count), exp_addr, address);
                compare_value($sformatf("write %0d data", write_count), exp_data, {8'h00, wr_data});
            end
            write_count++;
        end
    end

    initial begin : main
        int   k;
        int   gap;
        int   expected_gap;
        logic timed_out;
        logic stop;
        checks      = 0;
        error_count = 0;
        write_count = 0;
        reset       = 1'b1;
        load_patterns();
        hold_reset(10);
        // First cycle after release is the fetch at the reset vector
        expected_gap = 1;
        stop         = 1'b0;
        k            = 0;
        while (k < fetch_addr.size() && !stop) begin
            wait_for_fetch(gap, timed_out);
            if (timed_out) begin
                require_true(1'b0, $sformatf("core stopped fetching, no opcode fetch %0d at %h",
                                             k, fetch_addr[k]));
                stop = 1'b1;
            end else begin
                compare_value($sformatf("fetch %0d cycles", k), expected_gap[15:0], gap[15:0]);
                compare_value($sformatf("fetch %0d address", k), fetch_addr[k], address);
                if (fetch_kind[k] == REC_RESET) begin
                    // Store reaches its data cycle T3 three edges on
                    repeat (3) @(posedge clk);
                    #1 reset = 1'b1;
                    hold_reset(3);
                    expected_gap = 1;
                end else begin
                    expected_gap = fetch_gap[k];
                end
            end
            k++;
        end
        @(negedge clk);
        require_true(exp_wr_addr.size() == 0,
                     $sformatf("%0d expected writes never happened", exp_wr_addr.size()));
        $display("checks %0d, errors %0d", checks, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
